// ==== files.f ====
hdl/fcvt_pkg.sv
hdl/fcvt_f2i_pipe.sv
hdl/fcvt_i2f_pipe.sv
hdl/fcvt_sequencer.sv
hdl/fcvt_status_regs.sv
hdl/fcvt_top.sv
test/fcvt_checker.sv
test/fcvt_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= fcvt_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/fcvt_tb.sv ====
`timescale 1ns/1ns

module fcvt_tb;
  import fcvt_pkg::*;

  localparam int RST_CYCLES   = 8;
  localparam int GAP_MAX      = 3;   // idle cycles with en low between entries
  localparam int F2I_DONE_LAT = 6;   // accepting edge to done
  localparam int I2F_DONE_LAT = 10;

  logic              clk;
  logic              rst;
  logic              en;
  logic              start;
  cvt_mode_t         mode;
  logic [31:0]       data_in;
  logic              done;
  logic [31:0]       data_out;
  logic [STAT_W-1:0] f2i_count, i2f_count, sat_count;

  string       names[$];
  cvt_mode_t   modes[$];
  logic [31:0] inputs[$];
  logic [31:0] results[$];
  logic        sats[$];

  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          exp_f2i = 0;  // counter model
  int          exp_i2f = 0;
  int          exp_sat = 0;
  logic [31:0] last_out = '0;

  fcvt_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .start     (start),
    .mode      (mode),
    .data_in   (data_in),
    .done      (done),
    .data_out  (data_out),
    .f2i_count (f2i_count),
    .i2f_count (i2f_count),
    .sat_count (sat_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run();
    $display("Finished with errors");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      fail_run();
    end
  endtask

  task automatic check_counters(input string tag);
    compare_word({tag, " f2i_count"}, 32'(exp_f2i), 32'(f2i_count));
    compare_word({tag, " i2f_count"}, 32'(exp_i2f), 32'(i2f_count));
    compare_word({tag, " sat_count"}, 32'(exp_sat), 32'(sat_count));
  endtask

  task automatic add_entry(input string name, input cvt_mode_t m, input logic [31:0] a,
                           input logic [31:0] q, input logic s);
    names.push_back(name);
    modes.push_back(m);
    inputs.push_back(a);
    results.push_back(q);
    sats.push_back(s);
  endtask

  // expected words worked out by hand, f2i truncates and i2f rounds to nearest even
  task automatic load_table();
    add_entry("f2i_one",       MODE_F2I, 32'h3f80_0000, 32'h0000_0001, 1'b0);
    add_entry("f2i_1p5",       MODE_F2I, 32'h3fc0_0000, 32'h0000_0001, 1'b0);
    add_entry("f2i_m2p75",     MODE_F2I, 32'hc030_0000, 32'hffff_fffe, 1'b0);
    add_entry("f2i_0p75",      MODE_F2I, 32'h3f40_0000, 32'h0000_0000, 1'b0);
    add_entry("f2i_denorm",    MODE_F2I, 32'h0000_0001, 32'h0000_0000, 1'b0);
    add_entry("f2i_m1e6",      MODE_F2I, 32'hc974_2400, 32'hfff0_bdc0, 1'b0);
    add_entry("f2i_max_fit",   MODE_F2I, 32'h4eff_ffff, 32'h7fff_ff80, 1'b0);
    add_entry("f2i_min_int",   MODE_F2I, 32'hcf00_0000, 32'h8000_0000, 1'b0);
    add_entry("f2i_3e9",       MODE_F2I, 32'h4f32_d05e, 32'h7fff_ffff, 1'b1);
    add_entry("f2i_pos_inf",   MODE_F2I, 32'h7f80_0000, 32'h7fff_ffff, 1'b1);
    add_entry("f2i_neg_inf",   MODE_F2I, 32'hff80_0000, 32'h8000_0000, 1'b1);
    add_entry("f2i_nan",       MODE_F2I, 32'h7fc0_0000, 32'h8000_0000, 1'b1);
    add_entry("i2f_zero",      MODE_I2F, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry("i2f_seven",     MODE_I2F, 32'h0000_0007, 32'h40e0_0000, 1'b0);
    add_entry("i2f_minus_one", MODE_I2F, 32'hffff_ffff, 32'hbf80_0000, 1'b0);
    add_entry("i2f_min_int",   MODE_I2F, 32'h8000_0000, 32'hcf00_0000, 1'b0);
    add_entry("i2f_max_int",   MODE_I2F, 32'h7fff_ffff, 32'h4f00_0000, 1'b0);
    add_entry("i2f_tie_down",  MODE_I2F, 32'h0100_0001, 32'h4b80_0000, 1'b0);
    add_entry("i2f_tie_up",    MODE_I2F, 32'h0100_0003, 32'h4b80_0002, 1'b0);
    add_entry("i2f_round_up",  MODE_I2F, 32'h0200_0003, 32'h4c00_0001, 1'b0);
    add_entry("i2f_neg_tie",   MODE_I2F, 32'hfeff_fffd, 32'hcb80_0002, 1'b0);
  endtask

  // starts and ends on a falling edge
  task automatic apply_entry(input int i);
    int          lat;
    int          cycles;
    int          gap;
    logic [31:0] r;
    lat = (modes[i] == MODE_F2I) ? F2I_DONE_LAT : I2F_DONE_LAT;
    @(posedge clk);
    en      <= 1'b1;
    start   <= 1'b1;
    mode    <= modes[i];
    data_in <= inputs[i];
    @(posedge clk);  // accepting edge
    r = $urandom;
    start <= r[0];   // junk while busy
    @(negedge clk);
    cycles = 0;
    while (!done) begin
      if (cycles > lat) begin
        $display("%s: done did not arrive within %0d cycles", names[i], lat);
        fail_run();
      end
      compare_word({names[i], " hold"}, last_out, data_out);
      @(posedge clk);
      r = $urandom;
      start <= (cycles < lat - 1) ? r[0] : 1'b0;  // low again once the FSM goes idle
      @(negedge clk);
      cycles++;
    end
    compare_word({names[i], " latency"}, 32'(lat), 32'(cycles));
    compare_word(names[i], results[i], data_out);
    check_counters({names[i], " busy"});
    if (modes[i] == MODE_F2I) begin
      exp_f2i++;
      if (sats[i]) begin
        exp_sat++;
      end
    end else begin
      exp_i2f++;
    end
    last_out = results[i];
    @(negedge clk);
    compare_word({names[i], " single done"}, 32'd0, 32'(done));
    check_counters(names[i]);
    gap = $urandom_range(GAP_MAX, 0);
    repeat (gap) begin
      @(posedge clk);
      r = $urandom;
      en    <= 1'b0;
      start <= r[0];  // no effect with en low
      @(negedge clk);
      compare_word({names[i], " gap done"}, 32'd0, 32'(done));
      compare_word({names[i], " gap hold"}, last_out, data_out);
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
        $display("timeout after %0d cycles, the run did not complete", cycle_count);
        fail_run();
      end
    end
  end

  initial begin
    int n;
    int n_f2i;
    int n_i2f;
    int n_sat;
    void'($urandom(32'h7b22));
    rst     = 1'b1;
    en      = 1'b0;
    start   = 1'b0;
    mode    = MODE_F2I;
    data_in = 32'd0;
    load_table();
    n = names.size();
    cycle_limit = n * 16 + RST_CYCLES + 16;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_word("reset done", 32'd0, 32'(done));
    compare_word("reset data_out", 32'd0, data_out);
    check_counters("reset");
    for (int i = 0; i < n; i++) begin
      apply_entry(i);
    end
    n_f2i = 0;
    n_i2f = 0;
    n_sat = 0;
    for (int i = 0; i < n; i++) begin
      if (modes[i] == MODE_F2I) begin
        n_f2i++;
      end else begin
        n_i2f++;
      end
      n_sat += int'(sats[i]);
    end
    compare_word("final f2i_count", 32'(n_f2i), 32'(f2i_count));
    compare_word("final i2f_count", 32'(n_i2f), 32'(i2f_count));
    compare_word("final sat_count", 32'(n_sat), 32'(sat_count));
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== test/fcvt_checker.sv ====
`timescale 1ns/1ns

module fcvt_checker (
  input logic                         clk,
  input logic                         rst,
  input logic                         en,
  input logic                         start,
  input fcvt_pkg::cvt_mode_t          mode,
  input fcvt_pkg::seq_state_t         state,
  input logic                         f2i_en,
  input logic                         i2f_en,
  input logic                         done
);
  import fcvt_pkg::*;

  logic accept;

  assign accept = (state == ST_IDLE) && en && start;

  assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done high on two consecutive cycles");

  assert property (@(posedge clk) disable iff (rst) !(f2i_en && i2f_en))
    else $error("both pipeline enables high");

  // done is set on edge k+LAT+1 and sampled one edge later
  assert property (@(posedge clk) disable iff (rst)
                   (accept && mode == MODE_F2I) |=> !done [*6] ##1 done)
    else $error("f2i done not 6 cycles after acceptance");

  assert property (@(posedge clk) disable iff (rst)
                   (accept && mode == MODE_I2F) |=> !done [*10] ##1 done)
    else $error("i2f done not 10 cycles after acceptance");

endmodule

bind fcvt_sequencer fcvt_checker chk_i (
  .clk     (clk),
  .rst     (rst),
  .en      (en),
  .start   (start),
  .mode    (mode),
  .state   (state),
  .f2i_en  (f2i_en),
  .i2f_en  (i2f_en),
  .done    (done)
);

// ==== hdl/fcvt_top.sv ====
`timescale 1ns/1ns

module fcvt_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  logic                        start,
  input  fcvt_pkg::cvt_mode_t         mode,
  input  logic [31:0]                 data_in,
  output logic                        done,
  output logic [31:0]                 data_out,
  output logic [fcvt_pkg::STAT_W-1:0] f2i_count,
  output logic [fcvt_pkg::STAT_W-1:0] i2f_count,
  output logic [fcvt_pkg::STAT_W-1:0] sat_count
);
  import fcvt_pkg::*;

  logic        f2i_en, i2f_en;
  logic [31:0] f2i_q, i2f_q;
  logic        f2i_sat;
  cvt_mode_t   done_mode;
  logic        done_sat;

  fcvt_sequencer seq_i (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .start     (start),
    .mode      (mode),
    .f2i_q     (f2i_q),
    .i2f_q     (i2f_q),
    .f2i_sat   (f2i_sat),
    .f2i_en    (f2i_en),
    .i2f_en    (i2f_en),
    .done      (done),
    .done_mode (done_mode),
    .done_sat  (done_sat),
    .data_out  (data_out)
  );

  fcvt_f2i_pipe f2i_i (
    .clk (clk),
    .rst (rst),
    .en  (f2i_en),
    .a   (data_in),  // held stable by the requester until done
    .q   (f2i_q),
    .sat (f2i_sat)
  );

  fcvt_i2f_pipe i2f_i (
    .clk (clk),
    .rst (rst),
    .en  (i2f_en),
    .a   (data_in),
    .q   (i2f_q)
  );

  fcvt_status_regs stat_i (
    .clk       (clk),
    .rst       (rst),
    .done      (done),
    .done_mode (done_mode),
    .done_sat  (done_sat),
    .f2i_count (f2i_count),
    .i2f_count (i2f_count),
    .sat_count (sat_count)
  );

endmodule

// ==== hdl/fcvt_status_regs.sv ====
`timescale 1ns/1ns

module fcvt_status_regs (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        done,
  input  fcvt_pkg::cvt_mode_t         done_mode,
  input  logic                        done_sat,
  output logic [fcvt_pkg::STAT_W-1:0] f2i_count,
  output logic [fcvt_pkg::STAT_W-1:0] i2f_count,
  output logic [fcvt_pkg::STAT_W-1:0] sat_count
);
  import fcvt_pkg::*;

  // counters wrap, cleared only by reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      f2i_count <= '0;
      i2f_count <= '0;
      sat_count <= '0;
    end else if (done) begin
      if (done_mode == MODE_F2I) begin
        f2i_count <= f2i_count + 1'b1;
        if (done_sat) begin
          sat_count <= sat_count + 1'b1;  // saturated f2i result
        end
      end else begin
        i2f_count <= i2f_count + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/fcvt_sequencer.sv ====
`timescale 1ns/1ns

module fcvt_sequencer (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  logic                start,
  input  fcvt_pkg::cvt_mode_t mode,
  input  logic [31:0]         f2i_q,
  input  logic [31:0]         i2f_q,
  input  logic                f2i_sat,
  output logic                f2i_en,
  output logic                i2f_en,
  output logic                done,
  output fcvt_pkg::cvt_mode_t done_mode,
  output logic                done_sat,
  output logic [31:0]         data_out
);
  import fcvt_pkg::*;

  seq_state_t       state, nxt_state;
  logic [CNT_W-1:0] counter, counter_in;
  logic             done_in, done_sat_in;
  cvt_mode_t        done_mode_in;
  logic [31:0]      data_out_in;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= ST_IDLE;
      counter   <= '0;
      done      <= 1'b0;
      done_mode <= MODE_F2I;
      done_sat  <= 1'b0;
      data_out  <= '0;
    end else begin
      state     <= nxt_state;
      counter   <= counter_in;
      done      <= done_in;
      done_mode <= done_mode_in;
      done_sat  <= done_sat_in;
      data_out  <= data_out_in;
    end
  end

  always_comb begin
    f2i_en       = 1'b0;
    i2f_en       = 1'b0;
    done_in      = 1'b0;
    counter_in   = '0;
    nxt_state    = ST_IDLE;
    data_out_in  = data_out;  // hold between completions
    done_mode_in = done_mode;
    done_sat_in  = done_sat;
    case (state)
      ST_F2I: begin
        if (counter == F2I_LATENCY) begin
          done_in      = 1'b1;
          data_out_in  = f2i_q;
          done_mode_in = MODE_F2I;
          done_sat_in  = f2i_sat;
        end else begin
          counter_in = counter + 1'b1;
          f2i_en     = counter != F2I_LATENCY - 1'b1;  // accept edge already counted
          nxt_state  = ST_F2I;
        end
      end
      ST_I2F: begin
        if (counter == I2F_LATENCY) begin
          done_in      = 1'b1;
          data_out_in  = i2f_q;
          done_mode_in = MODE_I2F;
          done_sat_in  = 1'b0;
        end else begin
          counter_in = counter + 1'b1;
          i2f_en     = counter != I2F_LATENCY - 1'b1;
          nxt_state  = ST_I2F;
        end
      end
      default: begin
        if (en && start) begin
          if (mode == MODE_F2I) begin
            f2i_en    = 1'b1;
            nxt_state = ST_F2I;
          end else begin
            i2f_en    = 1'b1;
            nxt_state = ST_I2F;
          end
        end
      end
    endcase
  end

endmodule

// ==== hdl/fcvt_i2f_pipe.sv ====
`timescale 1ns/1ns

module fcvt_i2f_pipe (
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  logic [31:0] a,
  output logic [31:0] q
);

  logic [7:0]      sgn_d;   // sign, one bit per stage
  logic [7:0]      zero_d;  // input was zero
  logic [31:0]     s1_mag, s2_mag, s3_mag, s4_mag, s5_mag, s6_mag, s7_mag;
  logic [7:0][5:0] s2_lz;   // per nibble
  logic [3:0][5:0] s3_lz;   // per byte
  logic [1:0][5:0] s4_lz;   // per half word
  logic [5:0]      s5_lz;
  logic [2:0]      s6_fine;
  logic [7:0]      s6_exp, s7_exp, s8_exp;
  logic [24:0]     s8_sum;  // hidden bit + mantissa + carry
  logic            round_up;
  logic [7:0]      pack_exp;
  logic [22:0]     pack_man;

  function automatic logic [5:0] nib_lz(input logic [3:0] n);
    casez (n)
      4'b1???: nib_lz = 6'd0;
      4'b01??: nib_lz = 6'd1;
      4'b001?: nib_lz = 6'd2;
      4'b0001: nib_lz = 6'd3;
      default: nib_lz = 6'd4;
    endcase
  endfunction

  // an all-zero upper half of width w passes on to the lower half
  function automatic logic [5:0] lz_merge(input logic [5:0] hi, input logic [5:0] lo,
                                          input logic [5:0] w);
    lz_merge = (hi == w) ? w + lo : hi;
  endfunction

  // guard bit set and either sticky or odd lsb
  assign round_up = s7_mag[7] & ((|s7_mag[6:0]) | s7_mag[8]);
  assign pack_exp = s8_exp + {7'd0, s8_sum[24]};
  assign pack_man = s8_sum[24] ? s8_sum[23:1] : s8_sum[22:0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sgn_d  <= '0;
      zero_d <= '0;
    end else if (en) begin
      sgn_d  <= {sgn_d[6:0], a[31]};
      zero_d <= {zero_d[6:0], a == 32'd0};
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_mag <= a[31] ? -a : a;  // 32'h80000000 maps onto itself
      s2_mag <= s1_mag;
      for (int i = 0; i < 8; i++) begin
        s2_lz[i] <= nib_lz(s1_mag[4*i +: 4]);
      end
      s3_mag <= s2_mag;
      for (int j = 0; j < 4; j++) begin
        s3_lz[j] <= lz_merge(s2_lz[2*j+1], s2_lz[2*j], 6'd4);
      end
      s4_mag   <= s3_mag;
      s4_lz[1] <= lz_merge(s3_lz[3], s3_lz[2], 6'd8);
      s4_lz[0] <= lz_merge(s3_lz[1], s3_lz[0], 6'd8);
      s5_mag   <= s4_mag;
      s5_lz    <= lz_merge(s4_lz[1], s4_lz[0], 6'd16);
      s6_mag   <= s5_mag << {s5_lz[4:3], 3'b000};  // coarse normalise
      s6_fine  <= s5_lz[2:0];
      s6_exp   <= 8'd158 - {2'b00, s5_lz};  // 127 + 31 - lz
      s7_mag   <= s6_mag << s6_fine;
      s7_exp   <= s6_exp;
      s8_sum   <= {1'b0, s7_mag[31:8]} + {24'd0, round_up};
      s8_exp   <= s7_exp;
      q        <= zero_d[7] ? 32'd0 : {sgn_d[7], pack_exp, pack_man};
    end
  end

endmodule

// ==== hdl/fcvt_f2i_pipe.sv ====
`timescale 1ns/1ns

module fcvt_f2i_pipe (
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  logic [31:0] a,
  output logic [31:0] q,
  output logic        sat
);

  logic [3:0][4:0] fl_d;     // {sign, nan, inf, ovf, small} per stage
  logic [4:0]      fl_in;
  logic [7:0]      s1_exp;
  logic [23:0]     s1_mant;  // hidden bit included
  logic [7:0]      sh_full;
  logic [31:0]     s2_mag, s3_mag, s4_mag;
  logic            s2_left, s3_left;
  logic [4:0]      s2_sh;
  logic [1:0]      s3_sh;
  logic [31:0]     q_next;
  logic            sat_next;

  always_comb begin
    fl_in[4] = a[31];
    fl_in[3] = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);  // nan
    fl_in[2] = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);  // +/- inf
    // |x| >= 2^31, except exactly -2^31 which still fits
    fl_in[1] = (a[30:23] != 8'hff) && ((a[30:23] > 8'd158) ||
               ((a[30:23] == 8'd158) && !(a[31] && (a[22:0] == 23'd0))));
    fl_in[0] = a[30:23] < 8'd127;  // below 1, zero and denormals
  end

  // binary point sits 23 bits up, so exponent 150 means no shift
  assign sh_full = (s1_exp >= 8'd150) ? (s1_exp - 8'd150) : (8'd150 - s1_exp);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fl_d <= '0;
      sat  <= 1'b0;
    end else if (en) begin
      fl_d <= {fl_d[2:0], fl_in};
      sat  <= sat_next;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_exp  <= a[30:23];
      s1_mant <= {1'b1, a[22:0]};
      s2_mag  <= {8'd0, s1_mant};
      s2_left <= s1_exp >= 8'd150;
      s2_sh   <= sh_full[4:0];
      s3_mag  <= s2_left ? (s2_mag << {s2_sh[4:2], 2'b00}) : (s2_mag >> {s2_sh[4:2], 2'b00});
      s3_left <= s2_left;
      s3_sh   <= s2_sh[1:0];
      s4_mag  <= s3_left ? (s3_mag << s3_sh) : (s3_mag >> s3_sh);  // fraction bits gone
      q       <= q_next;
    end
  end

  always_comb begin
    q_next   = fl_d[3][4] ? -s4_mag : s4_mag;
    sat_next = 1'b0;
    if (fl_d[3][3]) begin
      q_next   = 32'h8000_0000;
      sat_next = 1'b1;
    end else if (fl_d[3][2] || fl_d[3][1]) begin
      q_next   = fl_d[3][4] ? 32'h8000_0000 : 32'h7fff_ffff;
      sat_next = 1'b1;
    end else if (fl_d[3][0]) begin
      q_next = 32'd0;
    end
  end

endmodule

// ==== hdl/fcvt_pkg.sv ====
package fcvt_pkg;

  localparam int CNT_W  = 4;   // sequencer latency counter
  localparam int STAT_W = 16;  // status counters

  // pipeline depth, also the last counter value in each busy state
  localparam logic [CNT_W-1:0] F2I_LATENCY = 4'd5;
  localparam logic [CNT_W-1:0] I2F_LATENCY = 4'd9;

  typedef enum logic {
    MODE_F2I = 1'b0,  // float32 -> int32, truncate
    MODE_I2F = 1'b1   // int32 -> float32, nearest even
  } cvt_mode_t;

  typedef enum logic [1:0] {
    ST_F2I,
    ST_I2F,
    ST_IDLE
  } seq_state_t;

endpackage
